// ==== logic/video_mode_pkg.sv ====
`default_nettype none

package video_mode_pkg;

	// Display modes coded as on the switches
	typedef enum logic [3:0] {
		VGA      = 4'b0000,	// 640x480
		SVGA     = 4'b0001,	// 800x600
		HDTV720P = 4'b0010,	// 1280x720
		XGA      = 4'b0011,	// 1024x768
		SXGA     = 4'b1000,	// 1280x1024
		CAMERA   = 4'b1001	// 1280x720 with camera porches
	} video_mode_e;

	typedef logic [10:0] coord_t;	// Raster coordinate

	// Terminal counts for one mode
	typedef struct packed {
		coord_t h_blank_start;
		coord_t h_sync_start;
		coord_t h_sync_end;
		coord_t h_blank_end;	// Last count of a line
		coord_t v_blank_start;
		coord_t v_sync_start;
		coord_t v_sync_end;
		coord_t v_blank_end;	// Last line of a frame
		logic   neg_sync;	// Sync pulses low
	} video_timing_t;

	// Raster outputs
	typedef struct packed {
		coord_t hcount;
		coord_t vcount;
		logic   hsync;
		logic   vsync;
		logic   de;
	} raster_t;

	function automatic video_timing_t mode_timing(input video_mode_e m);
		coord_t        hpix, hfp, hpw, hbp;	// Pixels, porches, pulse
		coord_t        vlin, vfp, vpw, vbp;	// Lines, porches, pulse
		video_timing_t t;
		t.neg_sync = 1'b0;
		case (m)
			VGA: begin
				{hpix, hfp, hpw, hbp} = {11'd640, 11'd16, 11'd96, 11'd48};
				{vlin, vfp, vpw, vbp} = {11'd480, 11'd11, 11'd2, 11'd31};
				t.neg_sync = 1'b1;
			end
			SVGA: begin
				{hpix, hfp, hpw, hbp} = {11'd800, 11'd40, 11'd128, 11'd88};
				{vlin, vfp, vpw, vbp} = {11'd600, 11'd1, 11'd4, 11'd23};
			end
			XGA: begin
				{hpix, hfp, hpw, hbp} = {11'd1024, 11'd24, 11'd136, 11'd160};
				{vlin, vfp, vpw, vbp} = {11'd768, 11'd3, 11'd6, 11'd29};
				t.neg_sync = 1'b1;
			end
			SXGA: begin
				{hpix, hfp, hpw, hbp} = {11'd1280, 11'd48, 11'd112, 11'd248};
				{vlin, vfp, vpw, vbp} = {11'd1024, 11'd1, 11'd3, 11'd38};
			end
			CAMERA: begin
				{hpix, hfp, hpw, hbp} = {11'd1280, 11'd110, 11'd39, 11'd220};
				{vlin, vfp, vpw, vbp} = {11'd720, 11'd4, 11'd4, 11'd22};
			end
			default: begin	// HDTV720P and unknown codes
				{hpix, hfp, hpw, hbp} = {11'd1280, 11'd110, 11'd40, 11'd220};
				{vlin, vfp, vpw, vbp} = {11'd720, 11'd5, 11'd5, 11'd20};
			end
		endcase
		t.h_blank_start = hpix - 11'd1;
		t.h_sync_start  = t.h_blank_start + hfp;
		t.h_sync_end    = t.h_sync_start + hpw;
		t.h_blank_end   = t.h_sync_end + hbp;
		t.v_blank_start = vlin - 11'd1;
		t.v_sync_start  = t.v_blank_start + vfp;
		t.v_sync_end    = t.v_sync_start + vpw;
		t.v_blank_end   = t.v_sync_end + vbp;
		return t;
	endfunction

endpackage

`default_nettype wire

// ==== logic/clkgen_prog_pkg.sv ====
`default_nettype none

package clkgen_prog_pkg;

	// Synthesizer ratio, each field holds value minus one
	typedef struct packed {
		logic [7:0] m;	// Multiply
		logic [7:0] d;	// Divide
	} md_pair_t;

	// Serial command opcodes, sent LSB first
	typedef enum logic [1:0] {
		LOAD_D = 2'b01,
		LOAD_M = 2'b10,
		GO     = 2'b11
	} clk_cmd_e;

	localparam int LOAD_BITS = 10;	// Opcode plus 8-bit value
	localparam int GO_BITS   = 2;	// Opcode only

	// Switch code to M/D
	function automatic md_pair_t mode_md(input logic [3:0] code);
		md_pair_t md;
		case (code)
			4'b0000: md = '{m: 8'd2 - 8'd1, d: 8'd4 - 8'd1};	// 25 MHz
			4'b0001: md = '{m: 8'd4 - 8'd1, d: 8'd5 - 8'd1};	// 40 MHz
			4'b0011: md = '{m: 8'd13 - 8'd1, d: 8'd10 - 8'd1};	// 65 MHz
			4'b1000: md = '{m: 8'd54 - 8'd1, d: 8'd25 - 8'd1};	// 108 MHz
			4'b1001: md = '{m: 8'd135 - 8'd1, d: 8'd91 - 8'd1};
			default: md = '{m: 8'd248 - 8'd1, d: 8'd167 - 8'd1};	// 74.25 MHz
		endcase
		return md;
	endfunction

endpackage

`default_nettype wire

// ==== logic/mode_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_select #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  wire                             clk50m_bufg,
	input  wire                             RSTBTN,
	input  wire  [3:0]                      sw,
	input  wire                             prog_ack,
	output logic                            prog_req,
	output clkgen_prog_pkg::md_pair_t       prog_md,
	output video_mode_pkg::video_mode_e     mode
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} state_e;

	state_e     state;
	logic [3:0] sw_meta, sw_sync;	// Synchronizer stages
	logic [3:0] cand;	// Code being debounced
	logic [CNT_W-1:0] stable_cnt;
	logic       stable;
	logic       pwrup;	// First cycle out of reset
	logic [3:0] req_code;
	video_mode_pkg::video_mode_e new_mode;

	// Unknown codes run as 720p
	function automatic video_mode_pkg::video_mode_e code_to_mode(input logic [3:0] code);
		case (code)
			video_mode_pkg::VGA, video_mode_pkg::SVGA, video_mode_pkg::HDTV720P,
			video_mode_pkg::XGA, video_mode_pkg::SXGA, video_mode_pkg::CAMERA:
				code_to_mode = video_mode_pkg::video_mode_e'(code);
			default: code_to_mode = video_mode_pkg::HDTV720P;
		endcase
	endfunction

	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
	end

	////////////////////////////////////////////////////////////
	// Debounce

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			cand       <= 4'd0;
			stable_cnt <= '0;
		end else if (sw_sync != cand) begin
			cand       <= sw_sync;	// Restart count on any change
			stable_cnt <= '0;
		end else if (stable_cnt != CNT_W'(DEBOUNCE_CYCLES - 1)) begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

	assign stable   = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));
	assign req_code = pwrup ? sw_sync : cand;	// Power-up skips debounce
	assign new_mode = code_to_mode(req_code);

	////////////////////////////////////////////////////////////
	// Four-phase handshake

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state    <= IDLE;
			prog_req <= 1'b0;
			pwrup    <= 1'b1;
			mode     <= video_mode_pkg::VGA;
		end else begin
			pwrup <= 1'b0;
			case (state)
				IDLE: if (pwrup || (stable && new_mode != mode)) begin
					mode     <= new_mode;
					prog_md  <= clkgen_prog_pkg::mode_md(new_mode);
					prog_req <= 1'b1;
					state    <= REQ;
				end
				REQ: if (prog_ack) begin
					prog_req <= 1'b0;
					state    <= WAIT_ACK_LOW;
				end
				default: if (!prog_ack) state <= IDLE;	// Ack low closes it
			endcase
		end
	end

	// Request held until the programmer acknowledges
	a_req_held: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		$fell(prog_req) |-> $past(prog_ack));

endmodule

`default_nettype wire

// ==== logic/clkgen_prog.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkgen_prog (
	input  wire                             clk50m_bufg,
	input  wire                             RSTBTN,
	input  wire                             prog_req,
	input  wire clkgen_prog_pkg::md_pair_t  prog_md,
	output logic                            prog_ack,
	output logic                            progen,
	output logic                            progdata
);

	localparam int LB    = clkgen_prog_pkg::LOAD_BITS;
	localparam int CNT_W = $clog2(LB);

	typedef enum logic [1:0] {IDLE, SHIFT, GAP, ACK} state_e;

	state_e          state;
	logic [1:0]      frame_idx;	// 0 load D, 1 load M, 2 go
	logic [CNT_W-1:0] bit_cnt;	// Bits left after the current one
	logic [LB-1:0]   shift_q;
	logic [1:0]      load_idx;
	logic [LB-1:0]   load_word;

	// Opcode in the low bits so it leaves first
	function automatic logic [LB-1:0] frame_word(input logic [1:0] idx,
			input clkgen_prog_pkg::md_pair_t md);
		case (idx)
			2'd0:    frame_word = {md.d, clkgen_prog_pkg::LOAD_D};
			2'd1:    frame_word = {md.m, clkgen_prog_pkg::LOAD_M};
			default: frame_word = {8'd0, clkgen_prog_pkg::GO};
		endcase
	endfunction

	function automatic logic [CNT_W-1:0] frame_last(input logic [1:0] idx);
		if (idx == 2'd2)
			frame_last = CNT_W'(clkgen_prog_pkg::GO_BITS - 1);
		else
			frame_last = CNT_W'(LB - 1);
	endfunction

	assign load_idx  = (state == IDLE) ? 2'd0 : frame_idx + 2'd1;
	assign load_word = frame_word(load_idx, prog_md);

	////////////////////////////////////////////////////////////
	// Command serializer

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state     <= IDLE;
			frame_idx <= 2'd0;
			bit_cnt   <= '0;
			prog_ack  <= 1'b0;
			progen    <= 1'b0;
			progdata  <= 1'b0;
		end else begin
			case (state)
				IDLE, GAP: begin
					if (state == GAP && frame_idx == 2'd2) begin
						prog_ack <= 1'b1;	// All three frames out
						state    <= ACK;
					end else if (state == GAP || prog_req) begin
						shift_q   <= load_word >> 1;
						progdata  <= load_word[0];
						progen    <= 1'b1;
						bit_cnt   <= frame_last(load_idx);
						frame_idx <= load_idx;
						state     <= SHIFT;
					end
				end
				SHIFT: begin
					if (bit_cnt != '0) begin
						progdata <= shift_q[0];
						shift_q  <= shift_q >> 1;
						bit_cnt  <= bit_cnt - 1'b1;
					end else begin
						progen   <= 1'b0;	// One idle cycle per frame
						progdata <= 1'b0;
						state    <= GAP;
					end
				end
				default: if (!prog_req) begin	// ACK
					prog_ack <= 1'b0;
					state    <= IDLE;
				end
			endcase
		end
	end

	a_quiet_bus: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		(state == IDLE || state == ACK) |-> !progen);

endmodule

`default_nettype wire

// ==== logic/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing (
	input  wire                             clk50m_bufg,
	input  wire                             RSTBTN,
	input  wire video_mode_pkg::video_mode_e mode,
	input  wire                             hold,	// Synthesizer being reprogrammed
	output video_mode_pkg::raster_t         raster
);

	video_mode_pkg::video_timing_t tim;
	video_mode_pkg::coord_t        hcount_q, vcount_q;
	logic hblnk, vblnk;
	logic hs_win, vs_win;
	logic hsync_q, vsync_q, de_q;

	assign tim = video_mode_pkg::mode_timing(mode);

	////////////////////////////////////////////////////////////
	// Counters

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || hold) begin
			hcount_q <= '0;	// Restart from top left
			vcount_q <= '0;
		end else if (hcount_q >= tim.h_blank_end) begin
			hcount_q <= '0;
			if (vcount_q >= tim.v_blank_end)
				vcount_q <= '0;	// End of frame
			else
				vcount_q <= vcount_q + 11'd1;
		end else begin
			hcount_q <= hcount_q + 11'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Blanking and sync windows

	assign hblnk  = (hcount_q > tim.h_blank_start);
	assign vblnk  = (vcount_q > tim.v_blank_start);
	assign hs_win = (hcount_q > tim.h_sync_start) && (hcount_q <= tim.h_sync_end);
	assign vs_win = (vcount_q > tim.v_sync_start) && (vcount_q <= tim.v_sync_end);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q <= tim.neg_sync;	// Inactive level
			vsync_q <= tim.neg_sync;
			de_q    <= 1'b0;
		end else begin
			hsync_q <= hs_win ^ tim.neg_sync;
			vsync_q <= vs_win ^ tim.neg_sync;
			de_q    <= !hblnk && !vblnk && !hold;	// No picture while held
		end
	end

	assign raster = '{
		hcount: hcount_q,
		vcount: vcount_q,
		hsync:  hsync_q,
		vsync:  vsync_q,
		de:     de_q
	};

	// Mode only changes while held, so the count stays in range
	a_hcount_range: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN || hold)
		hcount_q <= tim.h_blank_end);

endmodule

`default_nettype wire

// ==== logic/video_mode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_mode_top #(
	parameter int DEBOUNCE_CYCLES = 65536	// About 1.3 ms at 50 MHz
) (
	input  wire                             clk50m_bufg,
	input  wire                             RSTBTN,
	input  wire  [3:0]                      sw,
	output wire                             progen,	// Synthesizer command bus
	output wire                             progdata,
	output wire video_mode_pkg::raster_t    raster,
	output wire video_mode_pkg::video_mode_e mode
);

	logic                      prog_req, prog_ack;
	clkgen_prog_pkg::md_pair_t prog_md;

	////////////////////////////////////////////////////////////
	// Mode selection

	mode_select #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) i_mode_select (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.prog_ack   (prog_ack),
		.prog_req   (prog_req),
		.prog_md    (prog_md),
		.mode       (mode)
	);

	clkgen_prog i_clkgen_prog (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.prog_req   (prog_req),
		.prog_md    (prog_md),
		.prog_ack   (prog_ack),
		.progen     (progen),
		.progdata   (progdata)
	);

	// Raster held at origin while reprogramming
	video_timing i_video_timing (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.mode       (mode),
		.hold       (prog_req),
		.raster     (raster)
	);

endmodule

`default_nettype wire

// ==== tests/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_mode(input string what, input video_mode_pkg::video_mode_e exp,
		input video_mode_pkg::video_mode_e act);
	n_checks++;
	if (exp !== act) begin
		$display("FAIL %s %s: expected %s, got %s", test_name, what, exp.name(), act.name());
		n_errors++;
	end
endtask

task automatic check_md(input string what, input clkgen_prog_pkg::md_pair_t exp,
		input clkgen_prog_pkg::md_pair_t act);
	n_checks++;
	if (exp !== act) begin	// Fields shown as sent, value minus one
		$display("FAIL %s %s: expected m=%0d d=%0d, got m=%0d d=%0d",
			test_name, what, exp.m, exp.d, act.m, act.d);
		n_errors++;
	end
endtask

task automatic check_count(input string what, input video_mode_pkg::coord_t exp,
		input video_mode_pkg::coord_t act);
	n_checks++;
	if (exp !== act) begin
		$display("FAIL %s %s: expected %0d, got %0d", test_name, what, exp, act);
		n_errors++;
	end
endtask

task automatic check_cmd(input string what, input clkgen_prog_pkg::clk_cmd_e exp,
		input clkgen_prog_pkg::clk_cmd_e act);
	n_checks++;
	if (exp !== act) begin
		$display("FAIL %s %s: expected %s, got %b", test_name, what, exp.name(), act);
		n_errors++;
	end
endtask

task automatic check_level(input string what, input logic exp, input logic act);
	n_checks++;
	if (exp !== act) begin
		$display("FAIL %s %s: expected %b, got %b", test_name, what, exp, act);
		n_errors++;
	end
endtask

////////////////////////////////////////////////////////////
// Bounded waits, sampled on the falling edge

task automatic report_timeout(input string what);
	$display("ERROR %s: gave up waiting for %s", test_name, what);
	n_errors++;
endtask

task automatic wait_mode_change(input video_mode_pkg::video_mode_e old_mode,
		input int limit, output int n);
	for (n = 0; n < limit && mode == old_mode; n++)
		@(negedge clk50m_bufg);
	if (mode == old_mode)
		report_timeout("the active mode to change");
endtask

task automatic wait_progen(input int limit, output int n);
	for (n = 0; n < limit && !progen; n++)
		@(negedge clk50m_bufg);
	if (!progen)
		report_timeout("activity on the command bus");
endtask

`endif

// ==== tests/tb_video_mode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_video_mode_top;

	localparam int DEB        = 16;	// Debounce length under test
	localparam int LINE_LIMIT = 4000;	// Longer than any line

	logic clk50m_bufg;
	logic RSTBTN;
	logic [3:0] sw;
	logic progen, progdata;
	video_mode_pkg::raster_t     raster;
	video_mode_pkg::video_mode_e mode;

	int    n_checks, n_errors, n_tests, errs_at_start;
	string test_name;
	logic [31:0] lcg_state;

	video_mode_top #(
		.DEBOUNCE_CYCLES(DEB)
	) i_video_mode_top (
		.clk50m_bufg(clk50m_bufg),
		.RSTBTN     (RSTBTN),
		.sw         (sw),
		.progen     (progen),
		.progdata   (progdata),
		.raster     (raster),
		.mode       (mode)
	);

	`include "tb_checks.svh"

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;	// 50 MHz
	end

	////////////////////////////////////////////////////////////
	// Reference tables and helpers

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Synthesizer ratios per switch code sent as value minus one
	function automatic clkgen_prog_pkg::md_pair_t expected_md(input logic [3:0] code);
		int m, d;
		case (code)
			4'b0000: begin m = 2;   d = 4;   end
			4'b0001: begin m = 4;   d = 5;   end
			4'b0011: begin m = 13;  d = 10;  end
			4'b1000: begin m = 54;  d = 25;  end
			4'b1001: begin m = 135; d = 91;  end
			default: begin m = 248; d = 167; end	// 720p and unknown codes
		endcase
		return '{m: 8'(m - 1), d: 8'(d - 1)};
	endfunction

	function automatic video_mode_pkg::video_mode_e expected_mode(input logic [3:0] code);
		case (code)
			4'b0000: return video_mode_pkg::VGA;
			4'b0001: return video_mode_pkg::SVGA;
			4'b0011: return video_mode_pkg::XGA;
			4'b1000: return video_mode_pkg::SXGA;
			4'b1001: return video_mode_pkg::CAMERA;
			default: return video_mode_pkg::HDTV720P;
		endcase
	endfunction

	task automatic start_test(input string name);
		test_name     = name;
		errs_at_start = n_errors;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %s finished, %0d errors", test_name, n_errors - errs_at_start);
	endtask

	// Optional switch change then decode of one command stream
	task automatic program_check(input logic [3:0] code, input logic from_switch);
		video_mode_pkg::video_mode_e old_mode;
		clkgen_prog_pkg::md_pair_t   got_md;
		logic [9:0]             word [3];
		video_mode_pkg::coord_t flen [3];
		video_mode_pkg::coord_t prev_v;
		int nfr, bits, n, waited, last_hi;
		old_mode = mode;
		word     = '{default: '0};
		flen     = '{default: '0};
		nfr      = 0;
		bits     = 0;
		last_hi  = -1;
		prev_v   = '1;
		if (from_switch) begin
			@(posedge clk50m_bufg);
			sw <= code;
			@(negedge clk50m_bufg);
			wait_mode_change(old_mode, 64, n);
			check_count("switch to request", 11'(2 + DEB + 1), 11'(n));	// Sync, debounce, latch
		end
		check_mode("active mode", expected_mode(code), mode);
		wait_progen(1000, waited);
		if (from_switch)
			check_count("request to first bit", 11'd1, 11'(waited));
		// n counts cycles from the first command bit
		for (n = 0; n < 64; n++) begin
			if (progen) begin
				if (nfr < 3 && bits < 10)
					word[nfr][bits] = progdata;	// LSB first
				bits++;
				last_hi = n;
			end else if (bits != 0) begin	// Gap ends a frame
				if (nfr < 3)
					flen[nfr] = 11'(bits);
				nfr++;
				bits = 0;
			end
			if (n > 0 && raster.hcount != '0)
				break;	// Counters running again
			prev_v = raster.vcount;
			@(negedge clk50m_bufg);
		end
		if (n == 64)
			report_timeout("the raster to restart");
		check_count("frame count", 11'd3, 11'(nfr));
		check_count("load D length", 11'd10, flen[0]);
		check_count("load M length", 11'd10, flen[1]);
		check_count("go length", 11'd2, flen[2]);
		check_cmd("first opcode", clkgen_prog_pkg::LOAD_D, clkgen_prog_pkg::clk_cmd_e'(word[0][1:0]));
		check_cmd("second opcode", clkgen_prog_pkg::LOAD_M, clkgen_prog_pkg::clk_cmd_e'(word[1][1:0]));
		check_cmd("third opcode", clkgen_prog_pkg::GO, clkgen_prog_pkg::clk_cmd_e'(word[2][1:0]));
		got_md = '{m: word[1][9:2], d: word[0][9:2]};
		check_md("M/D values", expected_md(code), got_md);
		// Go frame ends 10+1+10+1+2 cycles in
		check_count("last command bit", 11'd23, 11'(last_hi));
		check_count("raster restart", 11'd27, 11'(n));	// Ack, req fall, first count
		check_count("first count after restart", 11'd1, raster.hcount);
		check_count("restart vcount", 11'd0, prev_v);
	endtask

	// One line from a leading hsync edge to the next
	task automatic measure_line(input logic neg, output int period, output int width,
			output int de_cnt, output logic idle);
		logic act, prev;
		int   n;
		act    = !neg;
		period = 0;
		width  = 0;
		de_cnt = 0;
		idle   = 1'bx;	// No enabled pixel seen yet
		prev   = raster.hsync;
		for (n = 0; n < LINE_LIMIT; n++) begin
			@(negedge clk50m_bufg);
			if (prev != act && raster.hsync == act)
				break;
			prev = raster.hsync;
		end
		if (n == LINE_LIMIT) begin
			report_timeout("an hsync leading edge");
			return;
		end
		for (n = 1; n < LINE_LIMIT; n++) begin
			if (raster.de) begin
				de_cnt++;
				idle = raster.hsync;	// Sync rests during active video
			end
			prev = raster.hsync;
			@(negedge clk50m_bufg);
			if (width == 0 && raster.hsync != act)
				width = n;
			if (prev != act && raster.hsync == act) begin
				period = n;
				break;
			end
		end
		if (period == 0)
			report_timeout("the next hsync leading edge");
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_powerup();
		start_test("reset_powerup");
		check_mode("mode after reset", video_mode_pkg::VGA, mode);
		check_level("hsync after reset", 1'b1, raster.hsync);	// VGA idles high
		check_level("vsync after reset", 1'b1, raster.vsync);
		check_level("de after reset", 1'b0, raster.de);
		check_level("progen after reset", 1'b0, progen);
		program_check(4'b0000, 1'b0);	// Power-up stream only
		end_test();
	endtask

	task automatic test_mode_change();
		logic [3:0] codes [7];
		int   per, wid, de_n;
		logic idle;
		codes = '{4'b0001, 4'b0010, 4'b0011, 4'b1000, 4'b1001, 4'b0111, 4'b0000};
		start_test("mode_change");
		foreach (codes[i]) begin
			program_check(codes[i], 1'b1);
			if (codes[i] == 4'b0111) begin	// Unknown code runs 720p
				measure_line(1'b0, per, wid, de_n, idle);
				check_count("720p line period", 11'd1650, 11'(per));	// 1280+110+40+220
				check_count("720p hsync width", 11'd40, 11'(wid));
			end
		end
		end_test();
	endtask

	task automatic test_debounce();
		logic [31:0] r;
		logic [3:0]  keep, code;
		logic        seen_prog, changed;
		int          len, c;
		start_test("debounce");
		keep      = sw;
		seen_prog = 1'b0;
		changed   = 1'b0;
		for (int g = 0; g < 8; g++) begin
			r    = lcg_next();
			len  = 1 + int'(r[23:16] % 8'd15);	// 1 to 15 cycles
			code = r[27:24];
			if (code == keep)
				code = ~keep;
			@(posedge clk50m_bufg);
			sw <= code;
			for (c = 0; c < len + 40; c++) begin
				@(negedge clk50m_bufg);
				seen_prog = seen_prog | progen;
				changed   = changed | (mode != expected_mode(keep));
				@(posedge clk50m_bufg);
				if (c == len - 1)
					sw <= keep;	// Glitch over
			end
		end
		check_level("command bus activity", 1'b0, seen_prog);
		check_level("mode changed", 1'b0, changed);
		check_mode("mode after glitches", expected_mode(keep), mode);
		end_test();
	endtask

	task automatic test_line_timing();
		int   per, wid, de_n;
		logic idle;
		start_test("line_timing");
		measure_line(1'b1, per, wid, de_n, idle);	// VGA sync is negative
		check_count("VGA line period", 11'd800, 11'(per));	// 640+16+96+48
		check_count("VGA hsync width", 11'd96, 11'(wid));
		program_check(4'b0001, 1'b1);
		measure_line(1'b0, per, wid, de_n, idle);
		check_count("SVGA line period", 11'd1056, 11'(per));	// 800+40+128+88
		check_count("SVGA hsync width", 11'd128, 11'(wid));
		end_test();
	endtask

	task automatic test_polarity_enable();
		int   per, wid, de_n;
		logic idle;
		start_test("polarity_enable");
		measure_line(1'b0, per, wid, de_n, idle);	// Still SVGA
		check_level("SVGA hsync idle", 1'b0, idle);
		check_level("SVGA vsync idle", 1'b0, raster.vsync);
		check_count("SVGA active pixels", 11'd800, 11'(de_n));
		program_check(4'b0011, 1'b1);	// XGA with negative sync
		measure_line(1'b1, per, wid, de_n, idle);
		check_level("XGA hsync idle", 1'b1, idle);
		check_level("XGA vsync idle", 1'b1, raster.vsync);
		check_count("XGA active pixels", 11'd1024, 11'(de_n));
		end_test();
	endtask

	////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		RSTBTN    = 1'b1;
		sw        = 4'b0000;
		n_checks  = 0;
		n_errors  = 0;
		n_tests   = 0;
		lcg_state = 32'he938;
		repeat (5) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		@(negedge clk50m_bufg);
		test_reset_powerup();
		test_mode_change();
		test_debounce();
		test_line_timing();
		test_polarity_enable();
		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
logic/video_mode_pkg.sv
logic/clkgen_prog_pkg.sv
logic/mode_select.sv
logic/clkgen_prog.sv
logic/video_timing.sv
logic/video_mode_top.sv
tests/tb_video_mode_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_video_mode_top
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
